/* hw/img_pkg.sv */
`default_nettype none

package img_pkg;

    // ========================================
    // Data widths
    // ========================================
    typedef logic [15:0] word_t;
    typedef logic [11:0] pixel_t;
    // Upper half holds the sum of sums, lower half the running sum
    typedef logic [31:0] checksum_t;
    typedef logic [17:0] stat_count_t;

    // ========================================
    // Capture constants
    // ========================================
    localparam int PIXEL_CLASS_BITS = 7;
    localparam int FLETCHER_MOD = 65535;
    localparam int CHECKSUM_WORDS = 2;
    // Sampling grid counters wrap every 4
    localparam int GRID_STEP_BITS = 2;

    typedef enum logic [1:0] {
        PX_MIDTONE,
        PX_HIGHLIGHT,
        PX_SHADOW
    } pixel_class_t;

    // Class is decided by the top bits of the pixel only
    function automatic pixel_class_t classify_pixel(input pixel_t px);
        logic [PIXEL_CLASS_BITS-1:0] top;
        top = px[$bits(pixel_t)-1 -: PIXEL_CLASS_BITS];
        if (&top) begin
            return PX_HIGHLIGHT;
        end
        if (top == '0) begin
            return PX_SHADOW;
        end
        return PX_MIDTONE;
    endfunction

endpackage

`default_nettype wire

/* hw/buffer_port_if.sv */
`default_nettype none
`timescale 1ns/1ns

interface buffer_port_if #(
    parameter int BLOCK_WORDS = 256
) ();

    localparam int ADDR_BITS = $clog2(BLOCK_WORDS);

    logic                 en;
    logic                 block;
    logic [ADDR_BITS-1:0] addr;
    logic [15:0]          data;

    // Write port, requester supplies the data
    modport wr_requester (output en, output block, output addr, output data);
    modport wr_memory    (input en, input block, input addr, input data);

    // Read port, memory returns data one cycle after en
    modport rd_requester (output en, output block, output addr, input data);
    modport rd_memory    (input en, input block, input addr, output data);

endinterface

`default_nettype wire

/* hw/frame_buffer.sv */
`default_nettype none
`timescale 1ns/1ns

module frame_buffer import img_pkg::*; #(
    parameter int BLOCK_WORDS = 256
) (
    input wire                  clk,
    buffer_port_if.wr_memory    wr,
    buffer_port_if.rd_memory    rd
);

    // ========================================
    // Storage, two blocks
    // ========================================
    word_t mem [0:1][0:BLOCK_WORDS-1];
    word_t rd_data_q;

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.block][wr.addr] <= wr.data;
        end
    end

    // Registered read, data valid the cycle after en
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data_q <= mem[rd.block][rd.addr];
        end
    end

    assign rd.data = rd_data_q;

    // ========================================
    // Checks
    // ========================================
    // Capture and readout are never active together
    a_port_exclusive: assert property (
        @(posedge clk) !(wr.en && rd.en)
    ) else $error("frame_buffer: read and write port enabled together");

endmodule

`default_nettype wire

/* hw/fletcher_checksum.sv */
`default_nettype none
`timescale 1ns/1ns

module fletcher_checksum import img_pkg::*; (
    input wire          clk,
    input wire          rst,
    input wire          clear,
    input wire          en,
    input word_t        din,
    output checksum_t   sum
);

    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [15:0] next_a;

    // One conditional subtract is enough since both inputs stay below 2*mod
    function automatic logic [15:0] mod_add(input logic [15:0] x, input logic [15:0] y);
        logic [16:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= 17'(FLETCHER_MOD)) begin
            s = s - 17'(FLETCHER_MOD);
        end
        return s[15:0];
    endfunction

    assign next_a = mod_add(sum_a, din);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= next_a;
            // Sum of sums uses the updated running sum
            sum_b <= mod_add(sum_b, next_a);
        end
    end

    assign sum = {sum_b, sum_a};

endmodule

`default_nettype wire

/* hw/pixel_stats.sv */
`default_nettype none
`timescale 1ns/1ns

module pixel_stats import img_pkg::*; (
    input wire              clk,
    input wire              rst,
    input wire              clear,
    input wire              en,
    input pixel_t           img_d,
    input wire              img_fv,
    input wire              img_lv,
    output stat_count_t     highlight_count,
    output stat_count_t     shadow_count
);

    // ========================================
    // Sampling grid position
    // ========================================
    logic [GRID_STEP_BITS-1:0] x_pos;
    logic [GRID_STEP_BITS-1:0] y_pos;
    logic                      lv_q;
    logic                      sample_q;
    pixel_t                    px_q;
    pixel_class_t              px_class;

    always_ff @(posedge clk) begin
        if (rst) begin
            x_pos <= '0;
            y_pos <= '0;
            lv_q <= 1'b0;
            sample_q <= 1'b0;
        end else begin
            lv_q <= img_lv;
            if (!img_lv) begin
                x_pos <= '0;
            end else begin
                x_pos <= x_pos + 1'b1;
            end
            // Next line starts on the falling edge of lv
            if (!img_fv) begin
                y_pos <= '0;
            end else if (lv_q && !img_lv) begin
                y_pos <= y_pos + 1'b1;
            end
            sample_q <= en && img_lv && (x_pos == '0) && (y_pos == '0);
        end
    end

    // Pixel is classified one cycle after it is sampled
    always_ff @(posedge clk) begin
        px_q <= img_d;
    end

    assign px_class = classify_pixel(px_q);

    // ========================================
    // Counters
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            highlight_count <= '0;
            shadow_count <= '0;
        end else if (sample_q) begin
            if (px_class == PX_HIGHLIGHT) begin
                highlight_count <= highlight_count + 1'b1;
            end
            if (px_class == PX_SHADOW) begin
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/capture_sequencer.sv */
`default_nettype none
`timescale 1ns/1ns

module capture_sequencer import img_pkg::*; #(
    parameter int HEADER_WORDS = 8,
    parameter int BLOCK_WORDS = 256,
    localparam int HDR_BITS = HEADER_WORDS * $bits(word_t),
    localparam int CNT_BITS = $clog2(BLOCK_WORDS + 1)
) (
    input wire                      clk,
    input wire                      rst,
    input wire                      start,
    input wire                      block,
    input wire [HDR_BITS-1:0]       header,
    input pixel_t                   img_d,
    input wire                      img_fv,
    input wire                      img_lv,
    buffer_port_if.wr_requester     wr,
    output logic                    done,
    output logic                    busy,
    output logic [CNT_BITS-1:0]     word_count,
    output stat_count_t             highlight_count,
    output stat_count_t             shadow_count
);

    localparam int ADDR_BITS = $clog2(BLOCK_WORDS);

    if (HEADER_WORDS + CHECKSUM_WORDS > BLOCK_WORDS) begin : g_size_check
        $error("capture_sequencer: header and checksum do not fit in a block");
    end

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_HEADER,
        ST_WAIT_FV_LOW,
        ST_WAIT_FV_HIGH,
        ST_FRAME,
        ST_CK_HIGH,
        ST_CK_LOW
    } state_t;

    state_t         state;
    logic [HDR_BITS-1:0] hdr_q;
    logic           blk_q;
    checksum_t      ck_q;
    checksum_t      ck_sum;
    logic           wr_en_c;
    word_t          wr_data_c;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            word_count <= '0;
        end else begin
            if (wr_en_c) begin
                word_count <= word_count + 1'b1;
            end
            case (state)
                ST_IDLE: if (start) state <= ST_CLEAR;
                ST_CLEAR: begin
                    word_count <= '0;
                    state <= ST_HEADER;
                end
                ST_HEADER: begin
                    if (word_count == CNT_BITS'(HEADER_WORDS - 1)) state <= ST_WAIT_FV_LOW;
                end
                // Skip any frame already in progress
                ST_WAIT_FV_LOW: if (!img_fv) state <= ST_WAIT_FV_HIGH;
                ST_WAIT_FV_HIGH: if (img_fv) state <= ST_FRAME;
                ST_FRAME: if (!img_fv) state <= ST_CK_HIGH;
                ST_CK_HIGH: state <= ST_CK_LOW;
                ST_CK_LOW: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Header and block are latched with the command
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            hdr_q <= header;
            blk_q <= block;
        end else if (state == ST_HEADER) begin
            hdr_q <= hdr_q << $bits(word_t);
        end
        if (state == ST_FRAME && !img_fv) begin
            ck_q <= ck_sum;
        end
    end

    // ========================================
    // Write port
    // ========================================
    always_comb begin
        wr_en_c = 1'b0;
        wr_data_c = '0;
        case (state)
            ST_HEADER: begin
                wr_en_c = 1'b1;
                wr_data_c = hdr_q[HDR_BITS-1 -: $bits(word_t)];
            end
            ST_FRAME: begin
                wr_en_c = img_fv && img_lv;
                wr_data_c = word_t'(img_d);
            end
            ST_CK_HIGH: begin
                wr_en_c = 1'b1;
                wr_data_c = ck_q[31:16];
            end
            ST_CK_LOW: begin
                wr_en_c = 1'b1;
                wr_data_c = ck_q[15:0];
            end
            default: ;
        endcase
    end

    assign wr.en = wr_en_c;
    assign wr.block = blk_q;
    assign wr.addr = word_count[ADDR_BITS-1:0];
    assign wr.data = wr_data_c;

    assign done = (state == ST_CK_LOW);
    assign busy = (state != ST_IDLE);

    // ========================================
    // Checksum and statistics
    // ========================================
    fletcher_checksum u_checksum (
        .clk   (clk),
        .rst   (rst),
        .clear (state == ST_CLEAR),
        .en    (wr_en_c && (state == ST_HEADER || state == ST_FRAME)),
        .din   (wr_data_c),
        .sum   (ck_sum)
    );

    pixel_stats u_stats (
        .clk             (clk),
        .rst             (rst),
        .clear           (state == ST_CLEAR),
        .en              (state == ST_FRAME),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    // Frame must fit in the block, otherwise the address would wrap
    a_addr_in_block: assert property (
        @(posedge clk) disable iff (rst) wr.en |-> word_count < CNT_BITS'(BLOCK_WORDS)
    ) else $error("capture_sequencer: write address beyond block");

endmodule

`default_nettype wire

/* hw/readout_engine.sv */
`default_nettype none
`timescale 1ns/1ns

module readout_engine import img_pkg::*; #(
    parameter int BLOCK_WORDS = 256,
    parameter int READOUT_CREDITS = 4,
    localparam int CNT_BITS = $clog2(BLOCK_WORDS + 1)
) (
    input wire                      clk,
    input wire                      rst,
    input wire                      start,
    input wire                      block,
    input wire [CNT_BITS-1:0]       word_count,
    buffer_port_if.rd_requester     rd,
    output logic                    readout_start,
    output logic                    readout_valid,
    output word_t                   readout_data,
    input wire                      readout_credit,
    output logic                    busy
);

    localparam int ADDR_BITS = $clog2(BLOCK_WORDS);
    localparam int CR_BITS = $clog2(READOUT_CREDITS + 1);

    logic                active;
    logic                blk_q;
    logic [CNT_BITS-1:0] len_q;
    logic [CNT_BITS-1:0] issued;
    logic [CNT_BITS-1:0] shown_cnt;
    logic [CNT_BITS-1:0] shown_next;
    logic [CR_BITS-1:0]  credits;
    logic                rd_en;
    logic                finish;

    // A read needs a credit left over after the word currently shown
    assign rd_en = active && (issued < len_q) && (credits > CR_BITS'(readout_valid));
    assign shown_next = shown_cnt + CNT_BITS'(readout_valid);
    assign finish = active && (shown_next == len_q);

    // ========================================
    // Sequencing
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            readout_start <= 1'b0;
            readout_valid <= 1'b0;
            issued <= '0;
            shown_cnt <= '0;
            credits <= '0;
        end else begin
            readout_start <= start && !active;
            readout_valid <= rd_en;
            if (!active) begin
                if (start) begin
                    active <= 1'b1;
                    issued <= '0;
                    shown_cnt <= '0;
                    credits <= CR_BITS'(READOUT_CREDITS);
                end
            end else begin
                if (finish) active <= 1'b0;
                if (rd_en) issued <= issued + 1'b1;
                shown_cnt <= shown_next;
                credits <= credits - CR_BITS'(readout_valid) + CR_BITS'(readout_credit);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !active) begin
            blk_q <= block;
            len_q <= word_count;
        end
    end

    assign rd.en = rd_en;
    assign rd.block = blk_q;
    assign rd.addr = issued[ADDR_BITS-1:0];
    assign readout_data = rd.data;
    assign busy = active;

    // ========================================
    // Credit checks
    // ========================================
    a_valid_has_credit: assert property (
        @(posedge clk) disable iff (rst) readout_valid |-> credits != '0
    ) else $error("readout_engine: word shown without credit");

    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst) credits <= CR_BITS'(READOUT_CREDITS)
    ) else $error("readout_engine: more credits returned than issued");

endmodule

`default_nettype wire

/* hw/img_controller.sv */
`default_nettype none
`timescale 1ns/1ns

module img_controller import img_pkg::*; #(
    parameter int HEADER_WORDS = 8,
    parameter int BLOCK_WORDS = 256,
    parameter int READOUT_CREDITS = 4,
    localparam int CNT_BITS = $clog2(BLOCK_WORDS + 1)
) (
    input wire                          clk,
    input wire                          rst,

    // Commands
    input wire                          cmd_capture,
    input wire                          cmd_readout,
    input wire                          cmd_block,
    input wire [HEADER_WORDS*16-1:0]    cmd_header,

    // Sensor port
    input pixel_t                       img_d,
    input wire                          img_fv,
    input wire                          img_lv,

    // Readout stream
    output logic                        readout_start,
    output logic                        readout_valid,
    output word_t                       readout_data,
    input wire                          readout_credit,

    // Status
    output logic                        status_capture_done,
    output logic [CNT_BITS-1:0]         status_word_count,
    output stat_count_t                 status_highlight_count,
    output stat_count_t                 status_shadow_count,
    output logic                        status_busy
);

    logic cap_busy;
    logic rd_busy;
    logic cap_start;
    logic rd_start;

    // Capture wins when both commands arrive together
    assign cap_start = cmd_capture && !rd_busy;
    assign rd_start = cmd_readout && !cap_busy && !cmd_capture;
    assign status_busy = cap_busy || rd_busy;

    buffer_port_if #(.BLOCK_WORDS(BLOCK_WORDS)) wr_port ();
    buffer_port_if #(.BLOCK_WORDS(BLOCK_WORDS)) rd_port ();

    // ========================================
    // Capture path
    // ========================================
    capture_sequencer #(
        .HEADER_WORDS (HEADER_WORDS),
        .BLOCK_WORDS  (BLOCK_WORDS)
    ) u_capture (
        .clk             (clk),
        .rst             (rst),
        .start           (cap_start),
        .block           (cmd_block),
        .header          (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .wr              (wr_port),
        .done            (status_capture_done),
        .busy            (cap_busy),
        .word_count      (status_word_count),
        .highlight_count (status_highlight_count),
        .shadow_count    (status_shadow_count)
    );

    frame_buffer #(.BLOCK_WORDS(BLOCK_WORDS)) u_buffer (
        .clk (clk),
        .wr  (wr_port),
        .rd  (rd_port)
    );

    // ========================================
    // Readout path
    // ========================================
    readout_engine #(
        .BLOCK_WORDS     (BLOCK_WORDS),
        .READOUT_CREDITS (READOUT_CREDITS)
    ) u_readout (
        .clk            (clk),
        .rst            (rst),
        .start          (rd_start),
        .block          (cmd_block),
        .word_count     (status_word_count),
        .rd             (rd_port),
        .readout_start  (readout_start),
        .readout_valid  (readout_valid),
        .readout_data   (readout_data),
        .readout_credit (readout_credit),
        .busy           (rd_busy)
    );

endmodule

`default_nettype wire

/* testbench/tb_img_controller.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_img_controller import img_pkg::*; ();

    localparam int HEADER_WORDS = 8;
    localparam int BLOCK_WORDS = 256;
    localparam int READOUT_CREDITS = 4;
    localparam int CNT_BITS = $clog2(BLOCK_WORDS + 1);
    localparam int MAX_PIXELS = 128;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       cmd_capture;
    logic                       cmd_readout;
    logic                       cmd_block;
    logic [HEADER_WORDS*16-1:0] cmd_header;
    pixel_t                     img_d;
    logic                       img_fv;
    logic                       img_lv;
    logic                       readout_start;
    logic                       readout_valid;
    word_t                      readout_data;
    logic                       readout_credit;
    logic                       status_capture_done;
    logic [CNT_BITS-1:0]        status_word_count;
    stat_count_t                status_highlight_count;
    stat_count_t                status_shadow_count;
    logic                       status_busy;

    // Frame slots: 0 first capture, 1 second capture, 2 frame that gets skipped
    pixel_t      frame_px [0:2][0:MAX_PIXELS-1];
    int          frame_w [0:2];
    int          frame_h [0:2];
    word_t       exp_words [0:1][0:BLOCK_WORDS-1];
    int          exp_len [0:1];
    checksum_t   exp_ck [0:1];
    stat_count_t exp_hi;
    stat_count_t exp_sh;
    int          last_len = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_start_errors = 0;
    logic        readout_window = 1'b0;
    logic        capture_window = 1'b0;
    int          watchdog_ns = 0;

    img_controller #(
        .HEADER_WORDS    (HEADER_WORDS),
        .BLOCK_WORDS     (BLOCK_WORDS),
        .READOUT_CREDITS (READOUT_CREDITS)
    ) uut (
        .clk                    (clk),
        .rst                    (rst),
        .cmd_capture            (cmd_capture),
        .cmd_readout            (cmd_readout),
        .cmd_block              (cmd_block),
        .cmd_header             (cmd_header),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .readout_start          (readout_start),
        .readout_valid          (readout_valid),
        .readout_data           (readout_data),
        .readout_credit         (readout_credit),
        .status_capture_done    (status_capture_done),
        .status_word_count      (status_word_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count),
        .status_busy            (status_busy)
    );

    always #5 clk = ~clk;

    // ========================================
    // Checks and reporting
    // ========================================
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic note_failure(input string msg);
        $display("At %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected 0x%04h, got 0x%04h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input stat_count_t expected,
                               input stat_count_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_checksum(input string name, input checksum_t expected,
                                  input checksum_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic check_status();
        check_count("status_word_count", stat_count_t'(last_len), stat_count_t'(status_word_count));
        check_count("status_highlight_count", exp_hi, status_highlight_count);
        check_count("status_shadow_count", exp_sh, status_shadow_count);
    endtask

    // Readout and capture outputs stay quiet outside their own windows
    always @(negedge clk) begin
        if (!rst && !readout_window && (readout_valid || readout_start)) begin
            note_failure("readout output active outside a readout");
        end
        if (!rst && !capture_window && status_capture_done) begin
            note_failure("status_capture_done pulsed outside a capture");
        end
    end

    // ========================================
    // Sensor and reference model
    // ========================================
    task automatic make_frame(input int f, input int w, input int h);
        int r;
        frame_w[f] = w;
        frame_h[f] = h;
        for (int i = 0; i < w * h; i++) begin
            r = $urandom % 4;
            // Biased toward both ends so highlights and shadows occur
            if (r == 0) frame_px[f][i] = 12'hfe0 | pixel_t'($urandom % 32);
            else if (r == 1) frame_px[f][i] = pixel_t'($urandom % 32);
            else frame_px[f][i] = pixel_t'($urandom);
        end
    endtask

    function automatic logic [HEADER_WORDS*16-1:0] random_header();
        logic [HEADER_WORDS*16-1:0] h;
        for (int i = 0; i < HEADER_WORDS; i++) h[i*16 +: 16] = word_t'($urandom);
        return h;
    endfunction

    task automatic build_model(input int blk, input int f, input logic [HEADER_WORDS*16-1:0] hdr);
        int a;
        int b;
        int n;
        int hi;
        int sh;
        pixel_t px;
        a = 0;
        b = 0;
        hi = 0;
        sh = 0;
        // Header goes out most significant word first
        for (int i = 0; i < HEADER_WORDS; i++) begin
            exp_words[blk][i] = hdr[(HEADER_WORDS-1-i)*16 +: 16];
        end
        n = HEADER_WORDS;
        for (int p = 0; p < frame_w[f] * frame_h[f]; p++) begin
            exp_words[blk][n] = {4'h0, frame_px[f][p]};
            n++;
        end
        for (int i = 0; i < n; i++) begin
            a = (a + int'(exp_words[blk][i])) % FLETCHER_MOD;
            b = (b + a) % FLETCHER_MOD;
        end
        exp_ck[blk] = {b[15:0], a[15:0]};
        exp_words[blk][n] = b[15:0];
        exp_words[blk][n+1] = a[15:0];
        exp_len[blk] = n + CHECKSUM_WORDS;
        // Every fourth pixel of every fourth line, starting at the origin
        for (int y = 0; y < frame_h[f]; y += 4) begin
            for (int x = 0; x < frame_w[f]; x += 4) begin
                px = frame_px[f][y * frame_w[f] + x];
                if (px[11:5] == 7'h7f) hi++;
                else if (px[11:5] == 7'h00) sh++;
            end
        end
        exp_hi = stat_count_t'(hi);
        exp_sh = stat_count_t'(sh);
    endtask

    task automatic send_frame(input int f);
        next_cycle;
        img_fv = 1'b1;
        for (int y = 0; y < frame_h[f]; y++) begin
            repeat (1 + $urandom % 3) next_cycle;
            for (int x = 0; x < frame_w[f]; x++) begin
                img_lv = 1'b1;
                img_d = frame_px[f][y * frame_w[f] + x];
                next_cycle;
            end
            img_lv = 1'b0;
            img_d = pixel_t'($urandom);
        end
        repeat (1 + $urandom % 3) next_cycle;
        img_fv = 1'b0;
        repeat (2 + $urandom % 3) next_cycle;
    endtask

    // ========================================
    // Command sequences
    // ========================================
    task automatic start_capture(input logic blk, input logic [HEADER_WORDS*16-1:0] hdr);
        next_cycle;
        cmd_capture = 1'b1;
        cmd_block = blk;
        cmd_header = hdr;
        next_cycle;
        cmd_capture = 1'b0;
    endtask

    task automatic wait_capture_done(input int blk);
        capture_window = 1'b1;
        @(negedge clk);
        while (!status_capture_done) @(negedge clk);
        // Count includes the last checksum word one cycle after done
        @(negedge clk);
        capture_window = 1'b0;
        last_len = exp_len[blk];
        check_status();
        if (status_busy) note_failure("status_busy still high after the capture finished");
    endtask

    task automatic run_readout(input logic blk, input bit slow, input bit interfere);
        int credits;
        int got;
        int cycle;
        int starts;
        int hold;
        int burst;
        word_t ck_hi;
        word_t ck_lo;
        credits = READOUT_CREDITS;
        got = 0;
        cycle = 0;
        starts = 0;
        hold = 0;
        burst = 0;
        ck_hi = '0;
        ck_lo = '0;
        readout_window = 1'b1;
        next_cycle;
        cmd_readout = 1'b1;
        cmd_block = blk;
        next_cycle;
        cmd_readout = 1'b0;
        while (got < last_len) begin
            readout_credit = 1'b0;
            if (slow) begin
                // Quiet stretch, then hand back what was spent one per cycle
                if (burst > 0) begin
                    readout_credit = 1'b1;
                    burst--;
                end else if (hold > 0) begin
                    hold--;
                end else begin
                    burst = READOUT_CREDITS - credits;
                    hold = 4 + $urandom % 12;
                end
            end else if (credits < READOUT_CREDITS) begin
                readout_credit = 1'($urandom % 2);
            end
            if (interfere) begin
                cmd_capture = (cycle == 2);
                cmd_readout = (cycle == 4);
                cmd_block = ~blk;
                cmd_header = random_header();
            end
            @(negedge clk);
            if (readout_start) starts++;
            if (readout_valid) begin
                if (credits == 0) note_failure("readout_valid high with no credits left");
                check_word($sformatf("readout_data[%0d]", got), exp_words[blk][got],
                           readout_data);
                if (got == last_len - 2) ck_hi = readout_data;
                if (got == last_len - 1) ck_lo = readout_data;
                got++;
                credits--;
            end
            if (readout_credit) credits++;
            cycle++;
            next_cycle;
        end
        readout_credit = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        readout_window = 1'b0;
        @(negedge clk);
        if (status_busy) note_failure("status_busy still high after the last readout word");
        if (starts != 1) note_failure("readout_start did not pulse exactly once");
        check_checksum("readout checksum", exp_ck[blk], {ck_hi, ck_lo});
        check_status();
        repeat (4) next_cycle;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        logic [HEADER_WORDS*16-1:0] hdr;
        int budget;
        void'($urandom(41));
        rst = 1'b1;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_block = 1'b0;
        cmd_header = '0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        readout_credit = 1'b0;
        // Second capture has the same size, so one readout length fits both blocks
        make_frame(0, 1 + $urandom % 16, 1 + $urandom % 8);
        make_frame(1, frame_w[0], frame_h[0]);
        make_frame(2, 16, 8);
        budget = 600;
        for (int f = 0; f < 3; f++) budget += frame_h[f] * (frame_w[f] + 4) + 40;
        budget += 5 * ((HEADER_WORDS + frame_w[0] * frame_h[0] + 2) * 8 + 40);
        watchdog_ns = budget * 10 * 2;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (20) begin
            @(negedge clk);
            if (status_busy) note_failure("status_busy high after reset with no command");
        end
        check_count("status_word_count", '0, stat_count_t'(status_word_count));
        check_count("status_highlight_count", '0, status_highlight_count);
        check_count("status_shadow_count", '0, status_shadow_count);
        end_test("reset_idle");

        hdr = random_header();
        build_model(0, 0, hdr);
        start_capture(1'b0, hdr);
        fork
            begin
                // Frame starts once the header words are written
                repeat (HEADER_WORDS + 2) next_cycle;
                send_frame(0);
            end
            wait_capture_done(0);
        join
        end_test("capture_block0");

        run_readout(1'b0, 1'b0, 1'b0);
        end_test("readout_block0");
        run_readout(1'b0, 1'b1, 1'b0);
        end_test("readout_block0_slow_credits");

        hdr = random_header();
        build_model(1, 1, hdr);
        fork
            send_frame(2);
            begin
                repeat (2) next_cycle;
                start_capture(1'b1, hdr);
                repeat (3) next_cycle;
                cmd_capture = 1'b1;
                cmd_readout = 1'b1;
                cmd_block = 1'b0;
                cmd_header = random_header();
                next_cycle;
                cmd_capture = 1'b0;
                cmd_readout = 1'b0;
            end
        join
        fork
            send_frame(1);
            wait_capture_done(1);
        join
        end_test("capture_block1_skip_frame");

        run_readout(1'b1, 1'b0, 1'b0);
        run_readout(1'b0, 1'b1, 1'b0);
        end_test("readout_both_blocks");

        run_readout(1'b1, 1'b1, 1'b1);
        end_test("commands_while_busy");

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/img_pkg.sv
hw/buffer_port_if.sv
hw/frame_buffer.sv
hw/fletcher_checksum.sv
hw/pixel_stats.sv
hw/capture_sequencer.sv
hw/readout_engine.sv
hw/img_controller.sv
testbench/tb_img_controller.sv

/* Makefile */
SOURCES := $(shell grep -v '^+' verilog.f)

.PHONY: run clean

obj_dir/Vtb_img_controller: verilog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_img_controller

run: obj_dir/Vtb_img_controller
	@out="$$(./obj_dir/Vtb_img_controller)"; echo "$$out"; \
	echo "$$out" | grep -q '^SIMULATION PASSED$$'

clean:
	rm -rf obj_dir
